// ==== dv/bus_checker.sv ====
`timescale 1ns/1ps

module bus_checker import soc_bus_pkg::*; (
    input  logic  clk_rv,
    input  logic  rst_rv,
    input  logic  req_valid,
    input  addr_t req_addr,
    input  data_t req_wdata,
    input  strb_t req_wstrb,
    input  logic  req_ready,
    input  data_t req_rdata,
    input  logic  fault_irq,
    input  logic  led_red,
    input  logic  led_green,
    input  logic  led_blue,
    input  logic  i2c_scl,
    input  logic  sda_drive_low,
    input  logic  sda_in,
    input  logic  usb_rst_n,
    input  logic  txd,
    output int    error_count,
    output int    frames_seen
);

    // Reference state, built from completed bus traffic
    data_t      ram_model [ram_index_t];
    delay_sel_t delay_m;
    logic [2:0] leds_m;
    logic       scl_m;
    logic       sda_m;
    logic       usb_m;
    logic       fault_m;
    int         fifo_level;
    logic       ser_busy_m;
    int         ser_left;
    byte_t      sent_m [$];

    // Request in flight: 0 idle, 1 strobe cycle, 2 response cycle
    int    phase;
    addr_t cur_addr;
    data_t cur_wdata;
    strb_t cur_wstrb;
    logic  take;
    logic  full_pre;
    data_t exp_data;

    // Frame decoder on txd
    logic  rx_busy;
    int    rx_cnt;
    int    bit_no;
    byte_t rx_shift;
    byte_t exp_byte;

    initial begin
        error_count = 0;
        frames_seen = 0;
    end

    function automatic region_t target_of(input addr_t a);
        if (a >= RAM_BASE)
            return REGION_RAM;
        if (a >= GPIO_BASE && a < GPIO_BASE + GPIO_SIZE)
            return REGION_GPIO;
        if (a == UART_DATA_ADDR)
            return REGION_UART_DATA;
        if (a == UART_STAT_ADDR)
            return REGION_UART_STAT;
        return REGION_NONE;
    endfunction

    function automatic data_t expected_read(input addr_t a);
        ram_index_t idx;
        logic [5:0] w;
        data_t      d;
        idx = a[12:2];
        w   = a[7:2];
        d   = '0;
        case (target_of(a))
            REGION_RAM: begin
                if (ram_model.exists(idx))
                    d = ram_model[idx];
                else
                    d = 'x;
            end
            REGION_GPIO: begin
                if (w == GPIO_DELAY_SEL)
                    d = {27'd0, delay_m};
                else if (w == GPIO_LEDS)
                    d = {29'd0, leds_m};
                else if (w == GPIO_I2C_SDA)
                    d = {31'd0, sda_in};
            end
            REGION_UART_STAT:
                d = {30'd0, fifo_level == UART_FIFO_DEPTH, fifo_level == 0 && !ser_busy_m};
            REGION_UART_DATA: d = '0;
            default:          d = UNMAPPED_DATA;
        endcase
        return d;
    endfunction

    // Write takes effect on the strobe edge
    task automatic apply_write(input logic full);
        ram_index_t idx;
        logic [5:0] w;
        data_t      merged;
        int         b;
        idx = cur_addr[12:2];
        w   = cur_addr[7:2];
        case (target_of(cur_addr))
            REGION_RAM: begin
                merged = ram_model.exists(idx) ? ram_model[idx] : 'x;
                for (b = 0; b < 4; b++)
                    if (cur_wstrb[b])
                        merged[8*b +: 8] = cur_wdata[8*b +: 8];
                ram_model[idx] = merged;
            end
            REGION_GPIO: begin
                if (w == GPIO_DELAY_SEL)
                    delay_m = cur_wdata[DELAY_SEL_W-1:0];
                else if (w == GPIO_LEDS)
                    leds_m = cur_wdata[2:0];
                else if (w == GPIO_I2C_SCL)
                    scl_m = cur_wdata[0];
                else if (w == GPIO_I2C_SDA)
                    sda_m = cur_wdata[0];
                else if (w == GPIO_USB_RSTN)
                    usb_m = cur_wdata[0];
            end
            REGION_UART_DATA: begin
                // A full FIFO drops the byte
                if (!full) begin
                    fifo_level++;
                    sent_m.push_back(cur_wdata[7:0]);
                end
            end
            default: ;
        endcase
    endtask

    // --------------------
    // Bus and pin monitor
    always @(posedge clk_rv) begin
        if (!rst_rv) begin
            phase      = 0;
            delay_m    = '0;
            leds_m     = '0;
            scl_m      = 1'b1;
            sda_m      = 1'b1;
            usb_m      = 1'b0;
            fault_m    = 1'b0;
            fifo_level = 0;
            ser_busy_m = 1'b0;
            ser_left   = 0;
            sent_m.delete();
        end else begin
            if ({led_blue, led_green, led_red} !== ~leds_m || i2c_scl !== scl_m ||
                sda_drive_low !== !sda_m || usb_rst_n !== usb_m) begin
                $display("CHECK FAILED at %0t: GPIO pins differ from written state", $time);
                error_count++;
            end
            if (fault_irq !== fault_m) begin
                $display("CHECK FAILED at %0t: fault_irq %b, expected %b", $time, fault_irq,
                         fault_m);
                error_count++;
            end
            if (!ser_busy_m && txd !== 1'b1) begin
                $display("CHECK FAILED at %0t: txd low while no frame is due", $time);
                error_count++;
            end
            if (req_ready !== (phase == 2)) begin
                $display("CHECK FAILED at %0t: req_ready %b off the two-cycle latency", $time,
                         req_ready);
                error_count++;
            end

            take     = !ser_busy_m && (fifo_level > 0);
            full_pre = (fifo_level == UART_FIFO_DEPTH);
            case (phase)
                0: begin
                    if (req_valid) begin
                        cur_addr  = req_addr;
                        cur_wdata = req_wdata;
                        cur_wstrb = req_wstrb;
                        phase     = 1;
                    end
                end
                1: begin
                    if (cur_wstrb != '0)
                        apply_write(full_pre);
                    if (target_of(cur_addr) == REGION_NONE)
                        fault_m = 1'b1;
                    phase = 2;
                end
                default: begin
                    exp_data = expected_read(cur_addr);
                    if (cur_wstrb == '0 && req_rdata !== exp_data) begin
                        $display("CHECK FAILED at %0t: read %h returned %h, expected %h",
                                 $time, cur_addr, req_rdata, exp_data);
                        error_count++;
                    end
                    phase = 0;
                end
            endcase

            // Serializer holds a byte for one 10-bit frame
            if (take) begin
                fifo_level--;
                ser_busy_m = 1'b1;
                ser_left   = 10 * UART_CLKS_PER_BIT;
            end else if (ser_busy_m) begin
                ser_left--;
                if (ser_left == 0)
                    ser_busy_m = 1'b0;
            end
        end
    end

    // --------------------
    // Frame decoder, samples each bit near its middle
    always @(posedge clk_rv) begin
        if (!rst_rv) begin
            rx_busy = 1'b0;
        end else if (!rx_busy) begin
            if (txd === 1'b0) begin
                rx_busy = 1'b1;
                rx_cnt  = 0;
            end
        end else begin
            rx_cnt++;
            bit_no = rx_cnt / UART_CLKS_PER_BIT;
            if (rx_cnt % UART_CLKS_PER_BIT == UART_CLKS_PER_BIT / 2 - 1) begin
                if (bit_no == 0 && txd !== 1'b0) begin
                    $display("CHECK FAILED at %0t: start bit not held low", $time);
                    error_count++;
                end else if (bit_no >= 1 && bit_no <= 8) begin
                    rx_shift = {txd, rx_shift[7:1]};
                end else if (bit_no == 9) begin
                    rx_busy = 1'b0;
                    frames_seen++;
                    if (txd !== 1'b1) begin
                        $display("CHECK FAILED at %0t: stop bit not high", $time);
                        error_count++;
                    end
                    if (sent_m.size() == 0) begin
                        $display("ERROR at %0t: frame %h sent with no byte accepted", $time,
                                 rx_shift);
                        error_count++;
                    end else begin
                        exp_byte = sent_m.pop_front();
                        if (rx_shift !== exp_byte) begin
                            $display("CHECK FAILED at %0t: frame %h, expected %h", $time,
                                     rx_shift, exp_byte);
                            error_count++;
                        end
                    end
                end
            end
        end
    end

endmodule

// ==== dv/tb_soc_bus.sv ====
`timescale 1ns/1ps

module tb_soc_bus import soc_bus_pkg::*; ();

    logic  clk_rv;
    logic  rst_rv;
    logic  req_valid;
    addr_t req_addr;
    data_t req_wdata;
    strb_t req_wstrb;
    logic  req_ready;
    data_t req_rdata;
    logic  fault_irq;
    logic  led_red;
    logic  led_green;
    logic  led_blue;
    logic  i2c_scl;
    logic  sda_drive_low;
    logic  sda_in;
    logic  usb_rst_n;
    logic  txd;

    int          error_count;
    int          frames_seen;
    int          seq_errors;
    int unsigned seed;
    int          i;
    int          frames_before;
    addr_t       a;
    data_t       rd;
    strb_t       st;
    event        run_abort;

    soc_bus_top u_dut (.*);

    bus_checker u_checker (.*);

    initial begin
        clk_rv = 1'b0;
        forever #4 clk_rv = ~clk_rv;
    end

    task automatic finish_run();
        $display("Errors: checker %0d, sequence %0d", error_count, seq_errors);
        if (error_count == 0 && seq_errors == 0)
            $display("Test passed");
        else
            $display("Test failed");
        $finish;
    endtask

    // Starts and ends on a falling edge and leaves req_valid low
    task automatic bus_access(input addr_t addr, input data_t wd, input strb_t sb,
                              output data_t rdata);
        int waited;
        req_valid = 1'b1;
        req_addr  = addr;
        req_wdata = wd;
        req_wstrb = sb;
        waited    = 0;
        rdata     = '0;
        while (req_ready !== 1'b1 && waited < 16) begin
            @(negedge clk_rv);
            waited++;
        end
        if (req_ready !== 1'b1) begin
            $display("ERROR at %0t: no req_ready for the access to %h", $time, addr);
            seq_errors++;
            -> run_abort;
            // The abort branch ends the sequence before this edge
            @(negedge clk_rv);
        end else begin
            rdata = req_rdata;
            @(negedge clk_rv);
            req_valid = 1'b0;
        end
    endtask

    task automatic bus_write(input addr_t addr, input data_t wd, input strb_t sb);
        data_t unused;
        bus_access(addr, wd, sb, unused);
    endtask

    task automatic bus_read(input addr_t addr, output data_t rdata);
        bus_access(addr, '0, '0, rdata);
    endtask

    // Poll UART status until the masked bits match
    task automatic wait_status(input data_t mask, input data_t value);
        data_t sv;
        int    polls;
        polls = 0;
        bus_read(UART_STAT_ADDR, sv);
        while ((sv & mask) !== value && polls < 400) begin
            bus_read(UART_STAT_ADDR, sv);
            polls++;
        end
        if ((sv & mask) !== value) begin
            $display("ERROR at %0t: UART status never reached %h under mask %h", $time,
                     value, mask);
            seq_errors++;
            -> run_abort;
            @(negedge clk_rv);
        end
    endtask

    function automatic addr_t gpio_addr(input int word);
        return GPIO_BASE + 4 * word;
    endfunction

    initial begin
        rst_rv     = 1'b0;
        req_valid  = 1'b0;
        req_addr   = '0;
        req_wdata  = '0;
        req_wstrb  = '0;
        sda_in     = 1'b1;
        seq_errors = 0;
        seed       = 32'h59595f98;
        void'($urandom(seed));
        repeat (2) @(negedge clk_rv);
        rst_rv = 1'b1;

        fork
            begin
                // --------------------
                // RAM with partial writes and a read of the same word 8 KB higher
                for (i = 0; i < 16; i++) begin
                    a  = RAM_BASE | ($urandom & 32'h0000_DFFC);
                    st = $urandom_range(15, 1);
                    bus_write(a, $urandom, 4'hF);
                    bus_write(a, $urandom, st);
                    bus_read(a, rd);
                    bus_read(a + 32'h2000, rd);
                end

                // --------------------
                // GPIO registers, pins and sda_in readback
                for (i = 0; i < 4; i++) begin
                    bus_write(gpio_addr(GPIO_DELAY_SEL), $urandom, 4'hF);
                    bus_read(gpio_addr(GPIO_DELAY_SEL), rd);
                    bus_write(gpio_addr(GPIO_LEDS), $urandom, 4'hF);
                    bus_read(gpio_addr(GPIO_LEDS), rd);
                    bus_write(gpio_addr(GPIO_I2C_SCL), $urandom, 4'hF);
                    bus_write(gpio_addr(GPIO_I2C_SDA), $urandom, 4'hF);
                    bus_write(gpio_addr(GPIO_USB_RSTN), $urandom, 4'hF);
                    sda_in = i[0];
                    bus_read(gpio_addr(GPIO_I2C_SDA), rd);
                end
                for (i = 2; i < 64; i++)
                    if (i != GPIO_I2C_SDA)
                        bus_read(gpio_addr(i), rd);

                // --------------------
                // Polled transmit
                frames_before = frames_seen;
                for (i = 0; i < 6; i++) begin
                    wait_status(32'h2, 32'h0);
                    bus_write(UART_DATA_ADDR, $urandom, 4'h1);
                end
                wait_status(32'h1, 32'h1);
                if (frames_seen - frames_before != 6) begin
                    $display("CHECK FAILED at %0t: %0d frames after polled transmit, expected 6",
                             $time, frames_seen - frames_before);
                    seq_errors++;
                end

                // Overflow with one byte in the serializer and four in the FIFO
                frames_before = frames_seen;
                for (i = 0; i < 6; i++)
                    bus_write(UART_DATA_ADDR, $urandom, 4'h1);
                bus_read(UART_STAT_ADDR, rd);
                if (rd[1] !== 1'b1) begin
                    $display("CHECK FAILED at %0t: status %h does not show FIFO full", $time,
                             rd);
                    seq_errors++;
                end
                wait_status(32'h1, 32'h1);
                if (frames_seen - frames_before != 5) begin
                    $display("CHECK FAILED at %0t: %0d frames after overflow, expected 5",
                             $time, frames_seen - frames_before);
                    seq_errors++;
                end

                // --------------------
                // Unmapped accesses and the sticky fault
                bus_read(32'h1000_0000, rd);
                bus_write(32'h0300_0108, $urandom, 4'hF);
                bus_read(gpio_addr(GPIO_LEDS), rd);
                bus_read(UART_STAT_ADDR, rd);
                if (fault_irq !== 1'b1) begin
                    $display("CHECK FAILED at %0t: fault_irq dropped after good accesses",
                             $time);
                    seq_errors++;
                end
                rst_rv = 1'b0;
                repeat (2) @(negedge clk_rv);
                rst_rv = 1'b1;
                if (fault_irq !== 1'b0) begin
                    $display("CHECK FAILED at %0t: fault_irq still high after reset", $time);
                    seq_errors++;
                end
                bus_read(gpio_addr(GPIO_LEDS), rd);
            end
            @(run_abort);
        join_any
        disable fork;
        finish_run();
    end

endmodule

// ==== list.f ====
logic/soc_bus_pkg.sv
logic/bus_fabric.sv
logic/scratch_ram.sv
logic/gpio_regs.sv
logic/uart_tx_fifo.sv
logic/uart_serializer.sv
logic/soc_bus_top.sv
dv/bus_checker.sv
dv/tb_soc_bus.sv

// ==== logic/bus_fabric.sv ====
`timescale 1ns/1ps

module bus_fabric import soc_bus_pkg::*; (
    input  logic       clk_rv,
    input  logic       rst_rv,
    input  logic       req_valid,
    input  addr_t      req_addr,
    input  data_t      req_wdata,
    input  strb_t      req_wstrb,
    output logic       req_ready,
    output data_t      req_rdata,
    output strb_t      ram_we,
    output ram_index_t word_index,
    output data_t      wdata,
    output logic       gpio_wr,
    output logic       gpio_rd,
    output logic       uart_push,
    input  data_t      ram_rdata,
    input  data_t      gpio_rdata,
    input  logic       fifo_full,
    input  logic       tx_empty,
    output logic       fault_irq
);

    typedef enum logic [1:0] {
        FAB_IDLE,
        FAB_ACCESS,
        FAB_RESP
    } fab_state_t;

    fab_state_t state;
    region_t    region;
    ram_index_t index_q;
    data_t      wdata_q;
    strb_t      wstrb_q;
    logic       accept;
    logic       in_access;
    logic       is_write;

    function automatic region_t decode_region(input addr_t addr);
        region_t r;
        if (addr >= RAM_BASE)
            r = REGION_RAM;
        else if ((addr >= GPIO_BASE) && (addr < GPIO_BASE + addr_t'(GPIO_SIZE)))
            r = REGION_GPIO;
        else if (addr == UART_DATA_ADDR)
            r = REGION_UART_DATA;
        else if (addr == UART_STAT_ADDR)
            r = REGION_UART_STAT;
        else
            r = REGION_NONE;
        return r;
    endfunction

    // --------------------
    // Access sequencing through capture, strobe and respond
    assign accept    = (state == FAB_IDLE) && req_valid;
    assign in_access = (state == FAB_ACCESS);
    assign is_write  = (wstrb_q != '0);

    always_ff @(posedge clk_rv) begin
        if (!rst_rv) begin
            state  <= FAB_IDLE;
            region <= REGION_NONE;
        end else begin
            case (state)
                FAB_IDLE: begin
                    if (req_valid) begin
                        state  <= FAB_ACCESS;
                        region <= decode_region(req_addr);
                    end
                end
                FAB_ACCESS: state <= FAB_RESP;
                default:    state <= FAB_IDLE;
            endcase
        end
    end

    // Request payload held for the target strobes
    always_ff @(posedge clk_rv) begin
        if (accept) begin
            index_q <= req_addr[12:2];
            wdata_q <= req_wdata;
            wstrb_q <= req_wstrb;
        end
    end

    assign word_index = index_q;
    assign wdata      = wdata_q;

    // One-cycle target strobes
    assign ram_we    = (in_access && (region == REGION_RAM)) ? wstrb_q : '0;
    assign gpio_wr   = in_access && (region == REGION_GPIO) && is_write;
    assign gpio_rd   = in_access && (region == REGION_GPIO) && !is_write;
    // Writes to a full FIFO are acknowledged but dropped
    assign uart_push = in_access && (region == REGION_UART_DATA) && is_write && !fifo_full;

    assign req_ready = (state == FAB_RESP);

    // --------------------
    // Read data select
    always_comb begin
        case (region)
            REGION_RAM:       req_rdata = ram_rdata;
            REGION_GPIO:      req_rdata = gpio_rdata;
            REGION_UART_STAT: req_rdata = {30'd0, fifo_full, tx_empty};
            REGION_UART_DATA: req_rdata = '0;
            default:          req_rdata = UNMAPPED_DATA;
        endcase
    end

    // Sticky fault on unmapped access
    always_ff @(posedge clk_rv) begin
        if (!rst_rv)
            fault_irq <= 1'b0;
        else if (in_access && (region == REGION_NONE))
            fault_irq <= 1'b1;
    end

    a_ready_pulse: assert property (@(posedge clk_rv) disable iff (!rst_rv)
        req_ready |=> !req_ready);

    // FIFO fills only through a push from this fabric
    a_full_needs_push: assert property (@(posedge clk_rv) disable iff (!rst_rv)
        $rose(fifo_full) |-> $past(uart_push));

endmodule

// ==== logic/gpio_regs.sv ====
`timescale 1ns/1ps

module gpio_regs import soc_bus_pkg::*; (
    input  logic       clk_rv,
    input  logic       rst_rv,
    input  logic       gpio_wr,
    input  logic       gpio_rd,
    input  ram_index_t word_index,
    input  data_t      wdata,
    output data_t      gpio_rdata,
    output logic       led_red,
    output logic       led_green,
    output logic       led_blue,
    output logic       i2c_scl,
    output logic       sda_drive_low,
    input  logic       sda_in,
    output logic       usb_rst_n
);

    gpio_word_t sel;
    delay_sel_t delay_sel;
    logic [2:0] leds;
    logic       scl_q;
    logic       sda_q;
    logic       usb_rstn_q;

    assign sel = word_index[GPIO_WORD_W-1:0];

    // --------------------
    // Register writes
    always_ff @(posedge clk_rv) begin
        if (!rst_rv) begin
            delay_sel  <= '0;
            leds       <= '0;
            scl_q      <= 1'b1;
            sda_q      <= 1'b1;
            usb_rstn_q <= 1'b0;
        end else if (gpio_wr) begin
            case (sel)
                GPIO_DELAY_SEL: delay_sel  <= wdata[DELAY_SEL_W-1:0];
                GPIO_LEDS:      leds       <= wdata[2:0];
                GPIO_I2C_SCL:   scl_q      <= wdata[0];
                GPIO_I2C_SDA:   sda_q      <= wdata[0];
                GPIO_USB_RSTN:  usb_rstn_q <= wdata[0];
                default:        ;
            endcase
        end
    end

    // Readback, unused words give zero
    always_ff @(posedge clk_rv) begin
        if (gpio_rd) begin
            case (sel)
                GPIO_DELAY_SEL: gpio_rdata <= {{(32 - DELAY_SEL_W){1'b0}}, delay_sel};
                GPIO_LEDS:      gpio_rdata <= {29'd0, leds};
                GPIO_I2C_SDA:   gpio_rdata <= {31'd0, sda_in};
                default:        gpio_rdata <= '0;
            endcase
        end
    end

    // LEDs are active low; bit 0 red, 1 green, 2 blue
    assign led_red       = !leds[0];
    assign led_green     = !leds[1];
    assign led_blue      = !leds[2];
    assign i2c_scl       = scl_q;
    assign sda_drive_low = !sda_q;
    assign usb_rst_n     = usb_rstn_q;

endmodule

// ==== logic/scratch_ram.sv ====
`timescale 1ns/1ps

module scratch_ram import soc_bus_pkg::*; (
    input  logic       clk_rv,
    input  strb_t      ram_we,
    input  ram_index_t word_index,
    input  data_t      wdata,
    output data_t      ram_rdata
);

    data_t mem [RAM_WORDS];

    // Byte lane writes
    always_ff @(posedge clk_rv) begin
        if (ram_we[0])
            mem[word_index][7:0] <= wdata[7:0];
        if (ram_we[1])
            mem[word_index][15:8] <= wdata[15:8];
        if (ram_we[2])
            mem[word_index][23:16] <= wdata[23:16];
        if (ram_we[3])
            mem[word_index][31:24] <= wdata[31:24];
    end

    // Registered read, ready one cycle after the index
    always_ff @(posedge clk_rv) begin
        ram_rdata <= mem[word_index];
    end

endmodule

// ==== logic/soc_bus_pkg.sv ====
package soc_bus_pkg;

    // Bus types
    typedef logic [31:0] addr_t;
    typedef logic [31:0] data_t;
    typedef logic [3:0]  strb_t;
    typedef logic [7:0]  byte_t;

    typedef enum logic [2:0] {
        REGION_NONE,
        REGION_RAM,
        REGION_GPIO,
        REGION_UART_DATA,
        REGION_UART_STAT
    } region_t;

    // --------------------
    // Memory map
    localparam addr_t RAM_BASE       = 32'hFFFF_0000;
    localparam addr_t GPIO_BASE      = 32'h0300_0000;
    localparam int    GPIO_SIZE      = 256;
    localparam addr_t UART_DATA_ADDR = 32'h0300_0100;
    localparam addr_t UART_STAT_ADDR = 32'h0300_0104;
    localparam data_t UNMAPPED_DATA  = 32'hFFFF_FFFF;

    // Internal RAM, 8 KB echoed across its window
    localparam int RAM_WORDS = 2048;
    typedef logic [$clog2(RAM_WORDS)-1:0] ram_index_t;

    // --------------------
    // GPIO word offsets inside the 256-byte window
    localparam int GPIO_WORD_W = $clog2(GPIO_SIZE / 4);
    typedef logic [GPIO_WORD_W-1:0] gpio_word_t;

    localparam gpio_word_t GPIO_DELAY_SEL = 6'd0;
    localparam gpio_word_t GPIO_LEDS      = 6'd1;
    localparam gpio_word_t GPIO_I2C_SCL   = 6'd5;
    localparam gpio_word_t GPIO_I2C_SDA   = 6'd6;
    localparam gpio_word_t GPIO_USB_RSTN  = 6'd7;

    localparam int DELAY_SEL_W = 5;
    typedef logic [DELAY_SEL_W-1:0] delay_sel_t;

    // --------------------
    // UART transmit path, bit rate kept short for simulation
    localparam int UART_FIFO_DEPTH   = 4;
    localparam int UART_CLKS_PER_BIT = 8;

    typedef logic [$clog2(UART_FIFO_DEPTH)-1:0] fifo_ptr_t;
    typedef logic [$clog2(UART_FIFO_DEPTH):0]   fifo_count_t;
    typedef logic [$clog2(UART_CLKS_PER_BIT)-1:0] bit_cnt_t;

endpackage

// ==== logic/soc_bus_top.sv ====
`timescale 1ns/1ps

module soc_bus_top import soc_bus_pkg::*; (
    input  logic  clk_rv,
    input  logic  rst_rv,
    input  logic  req_valid,
    input  addr_t req_addr,
    input  data_t req_wdata,
    input  strb_t req_wstrb,
    output logic  req_ready,
    output data_t req_rdata,
    output logic  fault_irq,
    output logic  led_red,
    output logic  led_green,
    output logic  led_blue,
    output logic  i2c_scl,
    output logic  sda_drive_low,
    input  logic  sda_in,
    output logic  usb_rst_n,
    output logic  txd
);

    // Fabric to targets
    strb_t      ram_we;
    ram_index_t word_index;
    data_t      wdata;
    logic       gpio_wr;
    logic       gpio_rd;
    logic       uart_push;
    data_t      ram_rdata;
    data_t      gpio_rdata;
    logic       fifo_full;
    logic       tx_empty;

    // FIFO to serializer
    logic  byte_valid;
    logic  byte_ready;
    byte_t tx_byte;
    logic  ser_busy;

    // --------------------
    bus_fabric u_fabric (
        .clk_rv     (clk_rv),
        .rst_rv     (rst_rv),
        .req_valid  (req_valid),
        .req_addr   (req_addr),
        .req_wdata  (req_wdata),
        .req_wstrb  (req_wstrb),
        .req_ready  (req_ready),
        .req_rdata  (req_rdata),
        .ram_we     (ram_we),
        .word_index (word_index),
        .wdata      (wdata),
        .gpio_wr    (gpio_wr),
        .gpio_rd    (gpio_rd),
        .uart_push  (uart_push),
        .ram_rdata  (ram_rdata),
        .gpio_rdata (gpio_rdata),
        .fifo_full  (fifo_full),
        .tx_empty   (tx_empty),
        .fault_irq  (fault_irq)
    );

    scratch_ram u_ram (
        .clk_rv     (clk_rv),
        .ram_we     (ram_we),
        .word_index (word_index),
        .wdata      (wdata),
        .ram_rdata  (ram_rdata)
    );

    gpio_regs u_gpio (
        .clk_rv        (clk_rv),
        .rst_rv        (rst_rv),
        .gpio_wr       (gpio_wr),
        .gpio_rd       (gpio_rd),
        .word_index    (word_index),
        .wdata         (wdata),
        .gpio_rdata    (gpio_rdata),
        .led_red       (led_red),
        .led_green     (led_green),
        .led_blue      (led_blue),
        .i2c_scl       (i2c_scl),
        .sda_drive_low (sda_drive_low),
        .sda_in        (sda_in),
        .usb_rst_n     (usb_rst_n)
    );

    // UART takes the low byte of the write word
    uart_tx_fifo u_tx_fifo (
        .clk_rv     (clk_rv),
        .rst_rv     (rst_rv),
        .uart_push  (uart_push),
        .push_byte  (wdata[7:0]),
        .byte_valid (byte_valid),
        .tx_byte    (tx_byte),
        .byte_ready (byte_ready),
        .ser_busy   (ser_busy),
        .fifo_full  (fifo_full),
        .tx_empty   (tx_empty)
    );

    uart_serializer u_serializer (
        .clk_rv     (clk_rv),
        .rst_rv     (rst_rv),
        .byte_valid (byte_valid),
        .tx_byte    (tx_byte),
        .byte_ready (byte_ready),
        .ser_busy   (ser_busy),
        .txd        (txd)
    );

endmodule

// ==== logic/uart_serializer.sv ====
`timescale 1ns/1ps

module uart_serializer import soc_bus_pkg::*; (
    input  logic  clk_rv,
    input  logic  rst_rv,
    input  logic  byte_valid,
    input  byte_t tx_byte,
    output logic  byte_ready,
    output logic  ser_busy,
    output logic  txd
);

    typedef enum logic [1:0] {
        IDLE,
        START,
        DATA,
        STOP
    } ser_state_t;

    ser_state_t state;
    bit_cnt_t   clk_cnt;
    logic [2:0] bit_idx;
    byte_t      shift_q;
    logic       bit_end;

    assign bit_end = (clk_cnt == bit_cnt_t'(UART_CLKS_PER_BIT - 1));

    // --------------------
    // Frame sequencer, LSB first
    always_ff @(posedge clk_rv) begin
        if (!rst_rv) begin
            state   <= IDLE;
            clk_cnt <= '0;
            bit_idx <= '0;
        end else begin
            clk_cnt <= (state == IDLE || bit_end) ? '0 : clk_cnt + 1'b1;
            case (state)
                IDLE: begin
                    if (byte_valid && byte_ready)
                        state <= START;
                end
                START: begin
                    if (bit_end) begin
                        state   <= DATA;
                        bit_idx <= '0;
                    end
                end
                DATA: begin
                    if (bit_end) begin
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7)
                            state <= STOP;
                    end
                end
                default: begin
                    if (bit_end)
                        state <= IDLE;
                end
            endcase
        end
    end

    // Shift register loads on handshake, shifts at each data bit end
    always_ff @(posedge clk_rv) begin
        if (byte_valid && byte_ready)
            shift_q <= tx_byte;
        else if (state == DATA && bit_end)
            shift_q <= {1'b0, shift_q[7:1]};
    end

    assign byte_ready = (state == IDLE);
    assign ser_busy   = (state != IDLE);
    assign txd = (state == START) ? 1'b0 : (state == DATA) ? shift_q[0] : 1'b1;

endmodule

// ==== logic/uart_tx_fifo.sv ====
`timescale 1ns/1ps

module uart_tx_fifo import soc_bus_pkg::*; (
    input  logic  clk_rv,
    input  logic  rst_rv,
    input  logic  uart_push,
    input  byte_t push_byte,
    output logic  byte_valid,
    output byte_t tx_byte,
    input  logic  byte_ready,
    input  logic  ser_busy,
    output logic  fifo_full,
    output logic  tx_empty
);

    byte_t       fifo_mem [UART_FIFO_DEPTH];
    fifo_ptr_t   wr_ptr;
    fifo_ptr_t   rd_ptr;
    fifo_count_t count;
    logic        pop;

    assign pop = byte_valid && byte_ready;

    // --------------------
    // Pointers and fill level
    always_ff @(posedge clk_rv) begin
        if (!rst_rv) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (uart_push)
                wr_ptr <= wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;
            case ({uart_push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk_rv) begin
        if (uart_push)
            fifo_mem[wr_ptr] <= push_byte;
    end

    // Head of queue, visible the cycle after a push
    assign tx_byte    = fifo_mem[rd_ptr];
    assign byte_valid = (count != '0);
    assign fifo_full  = (count == fifo_count_t'(UART_FIFO_DEPTH));
    // Nothing queued and last frame fully on the line
    assign tx_empty   = (count == '0) && !ser_busy;

    a_push_not_full: assert property (@(posedge clk_rv) disable iff (!rst_rv)
        uart_push |-> !fifo_full);

endmodule
